/* Makefile */
# Verilator build and run for the graph CU testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= kernel_cu_tb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx 'Everything OK' $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
hdl/cu_params_pkg.sv
hdl/cu_types_pkg.sv
hdl/cu_control_fsm.sv
hdl/request_counter.sv
hdl/memory_request_issuer.sv
hdl/response_collector.sv
hdl/kernel_cu_top.sv
verification/kernel_cu_chk.sv
verification/kernel_cu_tb.sv

/* hdl/cu_control_fsm.sv */
// ------------------------------
// Job state machine of the graph CU
// Walks idle, setup, run and finish for each descriptor
// Pulses phase_start into setup and run, done_out at the end
// ------------------------------
`timescale 1ns/1ns

module cu_control_fsm (
  input  logic                                  ap_clk,
  input  logic                                  areset_control,
  input  logic                                  descriptor_valid_reg,
  input  logic                                  all_issued,
  input  logic                                  all_returned,
  input  logic [cu_params_pkg::count_width-1:0] vertex_count,
  output cu_types_pkg::cu_phase_t               phase,
  output logic                                  phase_start,
  output logic                                  busy,
  output logic                                  done_out
);

  cu_types_pkg::cu_phase_t phase_next;
  // Current phase fully drained
  logic                    phase_complete;

  assign phase_complete = all_issued & all_returned;

  // ------------------------------
  // Next phase
  // ------------------------------
  always_comb begin
    phase_next  = phase;
    phase_start = 1'b0;
    unique case (phase)
      cu_types_pkg::phase_idle: begin
        // Registered descriptor starts a job
        if (descriptor_valid_reg) begin
          phase_next  = cu_types_pkg::phase_setup;
          phase_start = 1'b1;
        end
      end
      cu_types_pkg::phase_setup: begin
        if (phase_complete) begin
          // Empty vertex range skips the run phase
          if (vertex_count == '0) begin
            phase_next = cu_types_pkg::phase_finish;
          end else begin
            phase_next  = cu_types_pkg::phase_run;
            phase_start = 1'b1;
          end
        end
      end
      cu_types_pkg::phase_run: begin
        if (phase_complete) begin
          phase_next = cu_types_pkg::phase_finish;
        end
      end
      default: begin
        // Finish lasts one cycle
        phase_next = cu_types_pkg::phase_idle;
      end
    endcase
  end

  // ------------------------------
  // State and done pulse
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      phase    <= cu_types_pkg::phase_idle;
      done_out <= 1'b0;
    end else begin
      phase    <= phase_next;
      // Done lines up with the return to idle
      done_out <= (phase == cu_types_pkg::phase_finish);
    end
  end

  // Busy drops together with done_out
  assign busy = (phase != cu_types_pkg::phase_idle);

endmodule : cu_control_fsm

/* hdl/cu_params_pkg.sv */
// ------------------------------
// Numeric constants for the graph CU front end
// Widths, job layout, tag kind codes and address stride
// Used by scoped name from the type package and the RTL
// ------------------------------
package cu_params_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  // Byte address into graph memory
  localparam int addr_width = 32;
  // One memory word
  localparam int data_width = 32;
  // Vertex index and vertex count
  localparam int count_width = 16;
  // Job tag carried by the descriptor
  localparam int job_id_width = 8;

  // ------------------------------
  // Job layout
  // ------------------------------
  // Record word then initial sum word
  localparam logic [count_width-1:0] config_words = 2;
  // Byte stride between request addresses
  localparam logic [addr_width-1:0] word_bytes = 4;

  // ------------------------------
  // Response tag
  // ------------------------------
  // Kind bit that steers a response in the collector
  localparam logic tag_kind_config = 1'b0;
  localparam logic tag_kind_vertex = 1'b1;
  // Kind bit on top of the request index
  localparam int tag_width = 1 + count_width;

endpackage : cu_params_pkg

/* hdl/cu_types_pkg.sv */
// ------------------------------
// Structured types for the graph CU front end
// Descriptor, memory request and response, config decode
// Widths come from the params package
// ------------------------------
package cu_types_pkg;

  // Job descriptor as it arrives at the top
  typedef struct packed {
    logic [cu_params_pkg::addr_width-1:0]   base_addr;
    logic [cu_params_pkg::job_id_width-1:0] job_id;
  } descriptor_t;

  // Tag sent with a request and returned with its response
  typedef struct packed {
    logic                                  kind;
    logic [cu_params_pkg::tag_width-2:0]   index;
  } mem_tag_t;

  // One read request
  typedef struct packed {
    logic [cu_params_pkg::addr_width-1:0] addr;
    mem_tag_t                             tag;
  } mem_req_t;

  // One read response
  typedef struct packed {
    logic [cu_params_pkg::data_width-1:0] data;
    mem_tag_t                             tag;
  } mem_resp_t;

  // Config word 0 layout
  // Start index in the upper half
  typedef struct packed {
    logic [cu_params_pkg::count_width-1:0] vertex_start;
    logic [cu_params_pkg::count_width-1:0] vertex_count;
  } config_record_t;

  // Two views of one config word
  // Word 0 read as record, word 1 as raw sum
  typedef union packed {
    logic [cu_params_pkg::data_width-1:0] raw;
    config_record_t                       record;
  } config_word_u;

  // Job phase, also the FSM state
  typedef enum logic [1:0] {
    phase_idle,
    phase_setup,
    phase_run,
    phase_finish
  } cu_phase_t;

endpackage : cu_types_pkg

/* hdl/kernel_cu_top.sv */
// ------------------------------
// Top level of the graph CU front end
// Registers the descriptor and ties FSM, counter, issuer
// and collector to the memory request and response ports
// ------------------------------
`timescale 1ns/1ns

module kernel_cu_top (
  input  logic                                 ap_clk,
  input  logic                                 areset_control,
  input  logic                                 descriptor_valid,
  input  cu_types_pkg::descriptor_t            descriptor,
  input  logic                                 mem_stall,
  output logic                                 mem_req_valid,
  output cu_types_pkg::mem_req_t               mem_req,
  input  logic                                 mem_resp_valid,
  input  cu_types_pkg::mem_resp_t              mem_resp,
  output logic                                 busy,
  output logic                                 done_out,
  output logic [cu_params_pkg::data_width-1:0] result_sum
);

  logic                                  descriptor_valid_reg;
  cu_types_pkg::descriptor_t             descriptor_reg;
  logic                                  descriptor_accept;
  cu_types_pkg::cu_phase_t               phase;
  logic                                  phase_start;
  logic                                  all_issued;
  logic                                  all_returned;
  logic [cu_params_pkg::count_width-1:0] issue_index;
  logic                                  req_fire;
  logic                                  resp_fire;
  logic [cu_params_pkg::count_width-1:0] vertex_start;
  logic [cu_params_pkg::count_width-1:0] vertex_count;

  // ------------------------------
  // Descriptor register
  // ------------------------------
  // Only while idle and no job already pending
  assign descriptor_accept = descriptor_valid & ~busy & ~descriptor_valid_reg;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      descriptor_valid_reg <= 1'b0;
    end else begin
      descriptor_valid_reg <= descriptor_accept;
    end
  end

  // Payload kept for the whole job
  always_ff @(posedge ap_clk) begin
    if (descriptor_accept) begin
      descriptor_reg <= descriptor;
    end
  end

  // ------------------------------
  // Control and counting
  // ------------------------------
  cu_control_fsm i_fsm (
    .ap_clk               (ap_clk),
    .areset_control       (areset_control),
    .descriptor_valid_reg (descriptor_valid_reg),
    .all_issued           (all_issued),
    .all_returned         (all_returned),
    .vertex_count         (vertex_count),
    .phase                (phase),
    .phase_start          (phase_start),
    .busy                 (busy),
    .done_out             (done_out)
  );

  request_counter i_counter (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .phase          (phase),
    .phase_start    (phase_start),
    .req_fire       (req_fire),
    .resp_fire      (resp_fire),
    .vertex_count   (vertex_count),
    .issue_index    (issue_index),
    .all_issued     (all_issued),
    .all_returned   (all_returned)
  );

  // ------------------------------
  // Memory side
  // ------------------------------
  memory_request_issuer i_issuer (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .phase          (phase),
    .base_addr      (descriptor_reg.base_addr),
    .vertex_start   (vertex_start),
    .issue_index    (issue_index),
    .all_issued     (all_issued),
    .mem_stall      (mem_stall),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .req_fire       (req_fire)
  );

  response_collector i_collector (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .phase_start    (phase_start),
    .phase          (phase),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp       (mem_resp),
    .resp_fire      (resp_fire),
    .vertex_start   (vertex_start),
    .vertex_count   (vertex_count),
    .result_sum     (result_sum)
  );

endmodule : kernel_cu_top

/* hdl/memory_request_issuer.sv */
// ------------------------------
// Read request issuer of the graph CU
// Forms address and tag by phase, one request per cycle
// Holds a registered request while mem_stall is high
// ------------------------------
`timescale 1ns/1ns

module memory_request_issuer (
  input  logic                                  ap_clk,
  input  logic                                  areset_control,
  input  cu_types_pkg::cu_phase_t               phase,
  input  logic [cu_params_pkg::addr_width-1:0]  base_addr,
  input  logic [cu_params_pkg::count_width-1:0] vertex_start,
  input  logic [cu_params_pkg::count_width-1:0] issue_index,
  input  logic                                  all_issued,
  input  logic                                  mem_stall,
  output logic                                  mem_req_valid,
  output cu_types_pkg::mem_req_t                mem_req,
  output logic                                  req_fire
);

  localparam int pad_width = cu_params_pkg::addr_width - cu_params_pkg::count_width;

  logic                                 phase_active;
  logic                                 in_run;
  // Word offset from the base address
  logic [cu_params_pkg::addr_width-1:0] word_index;
  // Registered request not yet taken by memory
  logic                                 req_held;

  assign in_run       = (phase == cu_types_pkg::phase_run);
  assign phase_active = in_run || (phase == cu_types_pkg::phase_setup);

  // Config words sit at the base, vertex words after vertex_start
  always_comb begin
    word_index = {{pad_width{1'b0}}, issue_index};
    if (in_run) begin
      word_index = word_index + {{pad_width{1'b0}}, vertex_start};
    end
  end

  // Decision cycle, counted at the next edge
  assign req_fire = phase_active & ~all_issued & ~mem_stall;

  // ------------------------------
  // Request register
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      req_held <= 1'b0;
    end else begin
      // Keep the request across a stall
      req_held <= req_fire | (req_held & mem_stall);
    end
  end

  always_ff @(posedge ap_clk) begin
    if (req_fire) begin
      mem_req.addr      <= base_addr + word_index * cu_params_pkg::word_bytes;
      mem_req.tag.kind  <= in_run ? cu_params_pkg::tag_kind_vertex
                                  : cu_params_pkg::tag_kind_config;
      mem_req.tag.index <= issue_index;
    end
  end

  // Strobe only in cycles without stall
  assign mem_req_valid = req_held & ~mem_stall;

endmodule : memory_request_issuer

/* hdl/request_counter.sv */
// ------------------------------
// Issue and return counts for the active phase
// Cleared by phase_start, compared against the phase target
// ------------------------------
`timescale 1ns/1ns

module request_counter (
  input  logic                                  ap_clk,
  input  logic                                  areset_control,
  input  cu_types_pkg::cu_phase_t               phase,
  input  logic                                  phase_start,
  input  logic                                  req_fire,
  input  logic                                  resp_fire,
  input  logic [cu_params_pkg::count_width-1:0] vertex_count,
  output logic [cu_params_pkg::count_width-1:0] issue_index,
  output logic                                  all_issued,
  output logic                                  all_returned
);

  logic [cu_params_pkg::count_width-1:0] issued_count;
  logic [cu_params_pkg::count_width-1:0] returned_count;
  // Requests expected in this phase
  logic [cu_params_pkg::count_width-1:0] target;

  // Setup reads the config block, run one word per vertex
  always_comb begin
    unique case (phase)
      cu_types_pkg::phase_setup: target = cu_params_pkg::config_words;
      cu_types_pkg::phase_run:   target = vertex_count;
      default:                   target = '0;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control || phase_start) begin
      issued_count   <= '0;
      returned_count <= '0;
    end else begin
      if (req_fire) begin
        issued_count <= issued_count + 1'b1;
      end
      if (resp_fire) begin
        returned_count <= returned_count + 1'b1;
      end
    end
  end

  // Next request takes the issued count as its index
  assign issue_index  = issued_count;
  assign all_issued   = (issued_count == target);
  assign all_returned = (returned_count == target);

endmodule : request_counter

/* hdl/response_collector.sv */
// ------------------------------
// Response collector of the graph CU
// Routes tagged responses to config capture or accumulation
// Publishes the sum when the job reaches finish
// ------------------------------
`timescale 1ns/1ns

module response_collector (
  input  logic                                  ap_clk,
  input  logic                                  areset_control,
  input  logic                                  phase_start,
  input  cu_types_pkg::cu_phase_t               phase,
  input  logic                                  mem_resp_valid,
  input  cu_types_pkg::mem_resp_t               mem_resp,
  output logic                                  resp_fire,
  output logic [cu_params_pkg::count_width-1:0] vertex_start,
  output logic [cu_params_pkg::count_width-1:0] vertex_count,
  output logic [cu_params_pkg::data_width-1:0]  result_sum
);

  // Response word seen as record or raw data
  cu_types_pkg::config_word_u           resp_word;
  // Running sum of the current job
  logic [cu_params_pkg::data_width-1:0] acc;
  logic                                 is_config;
  logic                                 job_start;

  assign resp_word = mem_resp.data;
  assign is_config = (mem_resp.tag.kind == cu_params_pkg::tag_kind_config);
  // Setup entry, phase still idle at the pulse
  assign job_start = phase_start && (phase == cu_types_pkg::phase_idle);

  // ------------------------------
  // Return strobe to the counter
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      resp_fire <= 1'b0;
    end else begin
      resp_fire <= mem_resp_valid;
    end
  end

  // ------------------------------
  // Config capture and accumulation
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (job_start) begin
      // No stale config carried into a new job
      acc          <= '0;
      vertex_start <= '0;
      vertex_count <= '0;
    end else if (mem_resp_valid) begin
      if (is_config) begin
        if (mem_resp.tag.index == '0) begin
          vertex_start <= resp_word.record.vertex_start;
          vertex_count <= resp_word.record.vertex_count;
        end else begin
          // Word 1 seeds the sum
          acc <= resp_word.raw;
        end
      end else begin
        // Wraps modulo 2^32
        acc <= acc + resp_word.raw;
      end
    end
  end

  // ------------------------------
  // Published result
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      result_sum <= '0;
    end else if (phase == cu_types_pkg::phase_finish) begin
      // Same edge as done_out, held until the next job ends
      result_sum <= acc;
    end
  end

endmodule : response_collector

/* verification/kernel_cu_chk.sv */
// ------------------------------
// Port assertions for the graph CU top level
// Attached to kernel_cu_top by bind from the testbench
// failure_count is read back by the testbench at the end
// ------------------------------
`timescale 1ns/1ns

module kernel_cu_chk (
  input logic ap_clk,
  input logic areset_control,
  input logic mem_stall,
  input logic mem_req_valid,
  input logic busy,
  input logic done_out
);

  // Assertion failures so far
  int unsigned failure_count = 0;

  // Memory takes no request while stalled
  a_no_req_during_stall : assert property (
    @(posedge ap_clk) disable iff (areset_control) mem_stall |-> !mem_req_valid
  ) else begin
    failure_count++;
    $error("mem_req_valid high while mem_stall is high");
  end

  // End of job marker is a single-cycle pulse
  a_done_one_cycle : assert property (
    @(posedge ap_clk) disable iff (areset_control) done_out |=> !done_out
  ) else begin
    failure_count++;
    $error("done_out held for more than one cycle");
  end

  // Idle unit issues nothing
  a_no_req_when_idle : assert property (
    @(posedge ap_clk) disable iff (areset_control) !busy |-> !mem_req_valid
  ) else begin
    failure_count++;
    $error("mem_req_valid high while busy is low");
  end

endmodule : kernel_cu_chk

/* verification/kernel_cu_tb.sv */
// ------------------------------
// Testbench for the graph CU front end
// LFSR stimulus, memory model with stall, delay and reorder,
// reference sum and address sequence, one line per test
// ------------------------------
`timescale 1ns/1ns

module kernel_cu_tb;

  // ------------------------------
  // Run limits
  // ------------------------------
  localparam int max_vertices    = 20;
  // Worst case cycles per word under stall and delay
  localparam int cycles_per_word = 12;
  localparam int job_cycle_bound = 40 + cycles_per_word * (max_vertices + 2);
  localparam int idle_watch      = 30;
  // Four plain, one empty, four stalled, one strobed, reset pair
  localparam int job_total       = 12;
  localparam int timeout_cycles  = job_total * (job_cycle_bound + idle_watch) + 20;

  logic                                 ap_clk;
  logic                                 areset_control;
  logic                                 descriptor_valid;
  cu_types_pkg::descriptor_t            descriptor;
  logic                                 mem_stall;
  logic                                 mem_req_valid;
  cu_types_pkg::mem_req_t               mem_req;
  logic                                 mem_resp_valid;
  cu_types_pkg::mem_resp_t              mem_resp;
  logic                                 busy;
  logic                                 done_out;
  logic [cu_params_pkg::data_width-1:0] result_sum;

  // Memory contents by byte address
  logic [cu_params_pkg::data_width-1:0] mem_words [logic [cu_params_pkg::addr_width-1:0]];
  // Requests still to come, in issue order
  cu_types_pkg::mem_req_t               expected_reqs[$];
  // Accepted requests waiting for their response
  cu_types_pkg::mem_req_t               pending_reqs[$];
  int unsigned                          pending_ready[$];
  // Stall, random latency and reorder
  bit                                   memory_shuffle;
  logic [31:0]                          lfsr_state = 32'd19;
  int unsigned                          cycle_count = 0;
  int unsigned                          error_count = 0;
  int unsigned                          tests_run = 0;
  int unsigned                          tests_failed = 0;

  kernel_cu_top i_dut (
    .ap_clk           (ap_clk),
    .areset_control   (areset_control),
    .descriptor_valid (descriptor_valid),
    .descriptor       (descriptor),
    .mem_stall        (mem_stall),
    .mem_req_valid    (mem_req_valid),
    .mem_req          (mem_req),
    .mem_resp_valid   (mem_resp_valid),
    .mem_resp         (mem_resp),
    .busy             (busy),
    .done_out         (done_out),
    .result_sum       (result_sum)
  );

  bind kernel_cu_top kernel_cu_chk i_chk (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .mem_stall      (mem_stall),
    .mem_req_valid  (mem_req_valid),
    .busy           (busy),
    .done_out       (done_out)
  );

  // ------------------------------
  // Clock and watchdog
  // ------------------------------
  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  initial begin
    while (cycle_count < timeout_cycles) begin
      @(posedge ap_clk);
      cycle_count++;
    end
    $display("Timeout: run went past %0d clock cycles", timeout_cycles);
    $display("Something failed");
    $finish;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] random_bits(input int unsigned width);
    logic [31:0] value;
    logic        feedback;
    int unsigned i;
    value = '0;
    for (i = 0; i < width; i++) begin
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      value      = {value[30:0], feedback};
    end
    return value;
  endfunction

  // Testbench errors plus bound assertion failures
  function automatic int unsigned total_errors();
    return error_count + i_dut.i_chk.failure_count;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_request(input cu_types_pkg::mem_req_t got,
                               input cu_types_pkg::mem_req_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: request addr %h kind %b index %0d, expected %h %b %0d",
               $time, got.addr, got.tag.kind, got.tag.index,
               exp.addr, exp.tag.kind, exp.tag.index);
      error_count++;
    end
  endtask

  task automatic check_result(input logic [cu_params_pkg::data_width-1:0] got,
                              input logic [cu_params_pkg::data_width-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: result_sum %h, expected %h", $time, got, exp);
      error_count++;
    end
  endtask

  task automatic check_idle();
    if (busy !== 1'b0 || done_out !== 1'b0 || mem_req_valid !== 1'b0) begin
      $display("FAILED at %0t: unit not idle, busy %b done_out %b mem_req_valid %b",
               $time, busy, done_out, mem_req_valid);
      error_count++;
    end
  endtask

  // ------------------------------
  // Memory model
  // ------------------------------
  // One response per cycle, any ready entry when shuffling
  task automatic drive_response();
    int unsigned            ready_slots[$];
    int unsigned            slot;
    cu_types_pkg::mem_req_t req;
    mem_resp_valid = 1'b0;
    foreach (pending_ready[i]) begin
      if (pending_ready[i] <= cycle_count) begin
        ready_slots.push_back(i);
      end
    end
    if (ready_slots.size() != 0) begin
      slot = memory_shuffle ? ready_slots[random_bits(5) % ready_slots.size()]
                            : ready_slots[0];
      req  = pending_reqs[slot];
      pending_reqs.delete(slot);
      pending_ready.delete(slot);
      mem_resp_valid = 1'b1;
      mem_resp.tag   = req.tag;
      // Unknown addresses answer with the inverted address
      mem_resp.data  = mem_words.exists(req.addr) ? mem_words[req.addr] : ~req.addr;
    end
  endtask

  task automatic take_request();
    int unsigned delay;
    delay = memory_shuffle ? random_bits(3) % 6 : 0;
    if (expected_reqs.size() == 0) begin
      $display("Request to address %h arrived when none was expected", mem_req.addr);
      error_count++;
    end else begin
      check_request(mem_req, expected_reqs.pop_front());
    end
    pending_reqs.push_back(mem_req);
    pending_ready.push_back(cycle_count + 1 + delay);
  endtask

  initial begin
    mem_stall      = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp       = '0;
    forever begin
      @(negedge ap_clk);
      // Stall roughly one cycle in four
      mem_stall = memory_shuffle && (random_bits(2) == 0);
      drive_response();
      #1;
      if (areset_control) begin
        pending_reqs.delete();
        pending_ready.delete();
      end else if (mem_req_valid) begin
        take_request();
      end
    end
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  // Fills memory, queues expected requests, returns expected sum
  task automatic prepare_job(input cu_types_pkg::descriptor_t desc,
                             input logic [15:0] start,
                             input logic [15:0] count,
                             output logic [31:0] expected_sum);
    cu_types_pkg::config_record_t record;
    cu_types_pkg::mem_req_t       req;
    logic [15:0]                  index;
    logic [31:0]                  offset;
    mem_words.delete();
    expected_reqs.delete();
    record.vertex_start = start;
    record.vertex_count = count;
    mem_words[desc.base_addr]         = record;
    mem_words[desc.base_addr + 32'd4] = random_bits(32);
    expected_sum = mem_words[desc.base_addr + 32'd4];
    // Config words at the base
    for (index = 0; index < 16'd2; index++) begin
      req.addr      = desc.base_addr + {16'b0, index} * 32'd4;
      req.tag.kind  = cu_params_pkg::tag_kind_config;
      req.tag.index = index;
      expected_reqs.push_back(req);
    end
    // Vertex words, full width offset
    for (index = 0; index < count; index++) begin
      offset   = {16'b0, start} + {16'b0, index};
      req.addr = desc.base_addr + offset * 32'd4;
      if (!mem_words.exists(req.addr)) begin
        mem_words[req.addr] = random_bits(32);
      end
      expected_sum  = expected_sum + mem_words[req.addr];
      req.tag.kind  = cu_params_pkg::tag_kind_vertex;
      req.tag.index = index;
      expected_reqs.push_back(req);
    end
  endtask

  // ------------------------------
  // Job sequences
  // ------------------------------
  task automatic apply_reset();
    areset_control = 1'b1;
    repeat (5) @(negedge ap_clk);
    areset_control = 1'b0;
    #2;
  endtask

  task automatic random_descriptor(output cu_types_pkg::descriptor_t desc);
    desc.base_addr = random_bits(30) << 2;
    desc.job_id    = 8'(random_bits(8));
  endtask

  task automatic run_job(input logic [15:0] count, input bit strobe_while_busy);
    cu_types_pkg::descriptor_t desc;
    cu_types_pkg::descriptor_t ignored_desc;
    logic [31:0]               expected_sum;
    int unsigned               waited;
    bit                        done_seen;
    bit                        strobe_now;
    bit                        strobed;
    random_descriptor(desc);
    random_descriptor(ignored_desc);
    prepare_job(desc, 16'(random_bits(16)), count, expected_sum);
    waited     = 0;
    done_seen  = 1'b0;
    strobe_now = 1'b0;
    strobed    = 1'b0;
    @(negedge ap_clk);
    descriptor_valid = 1'b1;
    descriptor       = desc;
    while (!done_seen && waited < job_cycle_bound) begin
      @(negedge ap_clk);
      descriptor_valid = strobe_now;
      if (strobe_now) begin
        descriptor = ignored_desc;
      end
      #2;
      waited++;
      done_seen  = done_out;
      // One extra strobe just after busy rises, far from done
      strobe_now = strobe_while_busy && !strobed && busy;
      strobed    = strobed || strobe_now;
    end
    if (!done_seen) begin
      $display("No done_out within %0d cycles of the descriptor", job_cycle_bound);
      error_count++;
    end else begin
      check_result(result_sum, expected_sum);
      if (expected_reqs.size() != 0) begin
        $display("%0d expected requests were never issued", expected_reqs.size());
        error_count++;
      end
      // No second job, sum held
      repeat (idle_watch) begin
        @(negedge ap_clk);
        #2;
        check_idle();
      end
      check_result(result_sum, expected_sum);
    end
  endtask

  task automatic reset_mid_job();
    cu_types_pkg::descriptor_t desc;
    logic [31:0]               expected_sum;
    int unsigned               waited;
    random_descriptor(desc);
    prepare_job(desc, 16'(random_bits(16)), 16'(max_vertices), expected_sum);
    @(negedge ap_clk);
    descriptor_valid = 1'b1;
    descriptor       = desc;
    @(negedge ap_clk);
    descriptor_valid = 1'b0;
    // Wait until a few vertex reads are out
    waited = 0;
    while (expected_reqs.size() > 15 && waited < job_cycle_bound) begin
      @(negedge ap_clk);
      #2;
      waited++;
    end
    if (expected_reqs.size() > 15) begin
      $display("Job issued too few requests within %0d cycles before the reset",
               job_cycle_bound);
      error_count++;
    end
    @(negedge ap_clk);
    apply_reset();
    check_idle();
    check_result(result_sum, '0);
    expected_reqs.delete();
  endtask

  task automatic report_test(input string name, input int unsigned errors_before);
    tests_run++;
    if (total_errors() == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, total_errors() - errors_before);
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    int unsigned errors_before;
    int unsigned job;
    descriptor_valid = 1'b0;
    descriptor       = '0;
    memory_shuffle   = 1'b0;
    apply_reset();

    errors_before = total_errors();
    check_idle();
    check_result(result_sum, '0);
    for (job = 0; job < 4; job++) begin
      run_job(16'(1 + random_bits(5) % max_vertices), 1'b0);
    end
    report_test("random_jobs", errors_before);

    errors_before = total_errors();
    run_job(16'd0, 1'b0);
    report_test("zero_vertex_count", errors_before);

    errors_before  = total_errors();
    memory_shuffle = 1'b1;
    for (job = 0; job < 4; job++) begin
      run_job(16'(1 + random_bits(5) % max_vertices), 1'b0);
    end
    report_test("stall_and_reorder", errors_before);

    errors_before = total_errors();
    run_job(16'(1 + random_bits(5) % max_vertices), 1'b1);
    report_test("descriptor_while_busy", errors_before);

    errors_before = total_errors();
    reset_mid_job();
    run_job(16'(1 + random_bits(5) % max_vertices), 1'b0);
    report_test("reset_mid_job", errors_before);

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : kernel_cu_tb
